// ==== logic/commit_csr_pkg.sv ====
package commit_csr_pkg;

    // Datapath widths
    localparam int XLEN          = 64;
    localparam int CSR_ADDR_SIZE = 12;
    localparam int REG_ADDR_SIZE = 5;

    // Vector length granted when vsetvl asks for the maximum
    localparam int VLMAX = 64;

    typedef logic [XLEN-1:0]          bus64_t;
    typedef logic [CSR_ADDR_SIZE-1:0] csr_addr_t;
    typedef logic [REG_ADDR_SIZE-1:0] reg_addr_t;

    // Trap vector loaded into mtvec at reset
    localparam bus64_t RESET_VECTOR = 64'h0000_0000_0000_0100;

    // Implemented CSR addresses
    localparam csr_addr_t ADDR_FFLAGS   = 12'h001;
    localparam csr_addr_t ADDR_VXSAT    = 12'h009;
    localparam csr_addr_t ADDR_MTVEC    = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_MEPC     = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE   = 12'h342;
    localparam csr_addr_t ADDR_MTVAL    = 12'h343;
    localparam csr_addr_t ADDR_MINSTRET = 12'hB02;
    localparam csr_addr_t ADDR_VL       = 12'hC20;
    localparam csr_addr_t ADDR_VTYPE    = 12'hC21;

    // Instruction classes seen at commit
    typedef enum logic [4:0] {
        ALU,
        CSRRW,
        CSRRS,
        CSRRC,
        CSRRWI,
        CSRRSI,
        CSRRCI,
        ECALL,
        EBREAK,
        MRET,
        WFI,
        FENCE,
        FENCE_I,
        SFENCE_VMA,
        VSETVL,
        VSETVLI,
        VSETIVLI
    } instr_type_t;

    typedef enum logic [1:0] {
        NOT_MEM,
        LOAD,
        STORE,
        AMO
    } mem_type_t;

    // Commands understood by the CSR file
    typedef enum logic [3:0] {
        CSR_CMD_NOPE,
        CSR_CMD_WRITE,
        CSR_CMD_RW,
        CSR_CMD_READ,
        CSR_CMD_SET,
        CSR_CMD_CLEAR,
        CSR_CMD_SYS,
        CSR_CMD_VSETVL,
        CSR_CMD_VSETVLMAX
    } csr_cmd_t;

    // IEEE 754 exception flags, same bit order as fflags
    typedef struct packed {
        logic NV;
        logic DZ;
        logic OF;
        logic UF;
        logic NX;
    } fp_status_t;

    // One commit slot of the graduation list
    typedef struct packed {
        logic        valid;
        logic        ex_valid;        // Slot carries an exception
        instr_type_t instr_type;
        mem_type_t   mem_type;
        reg_addr_t   rd;
        reg_addr_t   rs1;             // Also the 5-bit immediate of CSR*I
        bus64_t      pc;
        fp_status_t  fp_status;
        logic        vs_ovf;          // Saturating vector op overflowed
        logic        fregfile_we;     // Writes the FP register file
        logic        stall_csr_fence;
    } gl_instruction_t;

    typedef struct packed {
        bus64_t cause;
        bus64_t origin;               // Faulting address or value for mtval
    } exception_t;

endpackage

// ==== logic/csr_req_if.sv ====
`timescale 1ns/1ps

interface csr_req_if;
    import commit_csr_pkg::*;

    // Request, valid while ena is high
    logic       ena;
    csr_cmd_t   cmd;
    csr_addr_t  addr;
    bus64_t     wdata;            // Exception origin when ena is low
    logic       exception;
    bus64_t     xcpt_cause;
    bus64_t     pc;
    logic [1:0] retire;
    fp_status_t fp_status;
    logic       vxsat;
    logic       freg_modified;

    // Same-cycle response
    bus64_t     rdata;
    logic       illegal;

    modport requester (
        output ena, cmd, addr, wdata, exception, xcpt_cause, pc, retire,
               fp_status, vxsat, freg_modified,
        input  rdata, illegal
    );

    modport responder (
        input  ena, cmd, addr, wdata, exception, xcpt_cause, pc, retire,
               fp_status, vxsat, freg_modified,
        output rdata, illegal
    );

endinterface

// ==== logic/csr_interface.sv ====
`timescale 1ns/1ps

module csr_interface (
    input  logic                                  commit_xcpt_i,      // Exception at commit
    input  commit_csr_pkg::bus64_t                result_gl_i,
    input  commit_csr_pkg::csr_addr_t             csr_addr_gl_i,
    input  commit_csr_pkg::csr_addr_t             vsetvl_vtype_i,
    input  commit_csr_pkg::gl_instruction_t [1:0] instruction_to_commit_i,
    input  logic                                  commit_store_or_amo_i,
    input  logic                                  mem_commit_stall_i, // Held at mem stage
    input  commit_csr_pkg::exception_t            exception_mem_commit_i,
    input  commit_csr_pkg::exception_t            exception_gl_i,
    output logic                                  csr_ena_int_o,
    output logic [1:0]                            retire_inst_o,
    csr_req_if.requester                          req
);
    import commit_csr_pkg::*;

    gl_instruction_t slot0;
    gl_instruction_t slot1;

    logic       csr_ena;
    csr_cmd_t   csr_cmd;
    csr_addr_t  csr_addr;
    bus64_t     csr_data;
    bus64_t     imm_data;
    logic       slot1_serial;   // Slot 1 must commit alone
    logic       commit_2_blocked;
    logic [1:0] csr_retire;

    assign slot0 = instruction_to_commit_i[0];
    assign slot1 = instruction_to_commit_i[1];

    assign imm_data = {{(XLEN-REG_ADDR_SIZE){1'b0}}, slot0.rs1};

    // Slot 0 decode into a CSR command
    always_comb begin
        csr_ena  = 1'b0;
        csr_cmd  = CSR_CMD_NOPE;
        csr_addr = csr_addr_gl_i;
        csr_data = '0;
        if (slot0.valid && !slot0.ex_valid) begin
            case (slot0.instr_type)
                CSRRW, CSRRWI: begin
                    csr_ena = 1'b1;
                    csr_cmd = (slot0.rd == '0) ? CSR_CMD_WRITE : CSR_CMD_RW;
                end
                CSRRS, CSRRSI: begin
                    csr_ena = 1'b1;
                    csr_cmd = (slot0.rs1 == '0) ? CSR_CMD_READ : CSR_CMD_SET;
                end
                CSRRC, CSRRCI: begin
                    csr_ena = 1'b1;
                    csr_cmd = (slot0.rs1 == '0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
                end
                ECALL, EBREAK, MRET, WFI, SFENCE_VMA: begin
                    csr_ena = 1'b1;
                    csr_cmd = CSR_CMD_SYS;
                end
                VSETVL, VSETVLI: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = (slot0.rs1 == '0) ? CSR_CMD_VSETVLMAX : CSR_CMD_VSETVL;
                    csr_addr = vsetvl_vtype_i;
                end
                VSETIVLI: begin
                    csr_ena  = 1'b1;
                    csr_cmd  = CSR_CMD_VSETVL;    // Immediate AVL never asks for max
                    csr_addr = vsetvl_vtype_i;
                end
                default: csr_ena = 1'b0;
            endcase

            // Register forms and vsetvl take the ALU result
            case (slot0.instr_type)
                CSRRWI, CSRRSI, CSRRCI:             csr_data = imm_data;
                CSRRW, CSRRS, CSRRC,
                VSETVL, VSETVLI, VSETIVLI:          csr_data = result_gl_i;
                default:                            csr_data = '0;
            endcase
        end
    end

    // Instructions that serialize commit when they sit in slot 1
    always_comb begin
        case (slot1.instr_type)
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
            ECALL, EBREAK, MRET, WFI,
            FENCE, FENCE_I, SFENCE_VMA,
            VSETVL, VSETVLI, VSETIVLI: slot1_serial = 1'b1;
            default:                   slot1_serial = 1'b0;
        endcase
    end

    assign commit_2_blocked = csr_ena
                            || !slot1.valid || slot1.ex_valid || slot1_serial
                            || (slot1.mem_type == STORE) || (slot1.mem_type == AMO)
                            || slot1.stall_csr_fence;

    // An excepting slot 0 leaves the pipe but does not count
    always_comb begin
        retire_inst_o = 2'b00;
        csr_retire    = 2'b00;
        if (slot0.valid && commit_xcpt_i) begin
            retire_inst_o = 2'b01;
        end else if (slot0.valid && !mem_commit_stall_i) begin
            retire_inst_o = commit_2_blocked ? 2'b01 : 2'b11;
            csr_retire    = retire_inst_o;
        end
    end

    assign csr_ena_int_o = csr_ena;

    assign req.ena  = csr_ena;
    assign req.cmd  = csr_cmd;
    assign req.addr = csr_ena ? csr_addr : '0;

    // Without a CSR access the data field carries the exception origin
    assign req.wdata = csr_ena ? csr_data :
                       commit_store_or_amo_i ? exception_mem_commit_i.origin :
                                               exception_gl_i.origin;

    assign req.xcpt_cause = commit_store_or_amo_i ? exception_mem_commit_i.cause
                                                  : exception_gl_i.cause;

    assign req.exception = commit_xcpt_i;
    assign req.pc        = slot0.pc;
    assign req.retire    = csr_retire;

    // Status gathered from whichever slots leave commit
    assign req.fp_status = (slot0.fp_status & {5{retire_inst_o[0]}})
                         | (slot1.fp_status & {5{retire_inst_o[1]}});

    assign req.vxsat = (retire_inst_o[0] & slot0.vs_ovf)
                     | (retire_inst_o[1] & slot1.vs_ovf);

    assign req.freg_modified = (retire_inst_o[0] & slot0.fregfile_we)
                             | (retire_inst_o[1] & slot1.fregfile_we);

endmodule

// ==== logic/csr_file.sv ====
`timescale 1ns/1ps

module csr_file (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    csr_req_if.responder           req,
    output logic                   fs_dirty_o,        // Sticky FP state dirty
    output logic                   redirect_valid_o,
    output commit_csr_pkg::bus64_t redirect_pc_o
);
    import commit_csr_pkg::*;

    // Architectural state
    bus64_t     mscratch_q, mepc_q, mcause_q, mtval_q, mtvec_q;
    bus64_t     vl_q, vtype_q, minstret_q;
    logic [4:0] fflags_q;
    logic       vxsat_q;

    // Next state
    bus64_t     mscratch_d, mepc_d, mcause_d, mtval_d, mtvec_d;
    bus64_t     vl_d, vtype_d, minstret_d;
    logic [4:0] fflags_d;
    logic       vxsat_d;

    bus64_t     csr_rval;
    logic       addr_known;
    logic       csr_access;       // Command touches the addressed CSR
    logic       csr_we;
    logic       vl_we;
    bus64_t     csr_wval;
    logic [4:0] fp_flags;
    logic [1:0] retire_cnt;

    // Read mux
    always_comb begin
        addr_known = 1'b1;
        case (req.addr)
            ADDR_MSCRATCH: csr_rval = mscratch_q;
            ADDR_MEPC:     csr_rval = mepc_q;
            ADDR_MCAUSE:   csr_rval = mcause_q;
            ADDR_MTVAL:    csr_rval = mtval_q;
            ADDR_MTVEC:    csr_rval = mtvec_q;
            ADDR_FFLAGS:   csr_rval = {{(XLEN-5){1'b0}}, fflags_q};
            ADDR_VXSAT:    csr_rval = {{(XLEN-1){1'b0}}, vxsat_q};
            ADDR_VL:       csr_rval = vl_q;
            ADDR_VTYPE:    csr_rval = vtype_q;
            ADDR_MINSTRET: csr_rval = minstret_q;
            default: begin
                csr_rval   = '0;
                addr_known = 1'b0;
            end
        endcase
    end

    assign csr_access = req.ena && (req.cmd != CSR_CMD_SYS) && (req.cmd != CSR_CMD_NOPE);

    assign req.rdata   = csr_rval;
    assign req.illegal = csr_access && !addr_known;

    // Read-modify-write value
    always_comb begin
        case (req.cmd)
            CSR_CMD_SET:   csr_wval = csr_rval | req.wdata;
            CSR_CMD_CLEAR: csr_wval = csr_rval & ~req.wdata;
            default:       csr_wval = req.wdata;    // WRITE and RW
        endcase
    end

    assign csr_we = csr_access && addr_known
                 && ((req.cmd == CSR_CMD_WRITE) || (req.cmd == CSR_CMD_RW)
                 ||  (req.cmd == CSR_CMD_SET)   || (req.cmd == CSR_CMD_CLEAR));

    assign vl_we = csr_access && addr_known
                && ((req.cmd == CSR_CMD_VSETVL) || (req.cmd == CSR_CMD_VSETVLMAX));

    assign fp_flags   = req.fp_status;
    assign retire_cnt = {1'b0, req.retire[0]} + {1'b0, req.retire[1]};

    // An explicit write beats the accumulators
    always_comb begin
        mscratch_d = mscratch_q;
        mepc_d     = mepc_q;
        mcause_d   = mcause_q;
        mtval_d    = mtval_q;
        mtvec_d    = mtvec_q;
        vl_d       = vl_q;
        vtype_d    = vtype_q;
        fflags_d   = fflags_q | fp_flags;
        vxsat_d    = vxsat_q | req.vxsat;
        minstret_d = minstret_q + {{(XLEN-2){1'b0}}, retire_cnt};

        if (req.exception) begin
            // Trap entry updates no addressed CSR
            mcause_d = req.xcpt_cause;
            mepc_d   = req.pc;
            mtval_d  = req.wdata;
        end else if (csr_we) begin
            case (req.addr)
                ADDR_MSCRATCH: mscratch_d = csr_wval;
                ADDR_MEPC:     mepc_d     = csr_wval;
                ADDR_MCAUSE:   mcause_d   = csr_wval;
                ADDR_MTVAL:    mtval_d    = csr_wval;
                ADDR_MTVEC:    mtvec_d    = csr_wval;
                ADDR_FFLAGS:   fflags_d   = csr_wval[4:0];
                ADDR_VXSAT:    vxsat_d    = csr_wval[0];
                ADDR_VL:       vl_d       = csr_wval;
                ADDR_VTYPE:    vtype_d    = csr_wval;
                ADDR_MINSTRET: minstret_d = csr_wval;
                default:       ;
            endcase
        end else if (vl_we) begin
            vl_d = (req.cmd == CSR_CMD_VSETVLMAX) ? bus64_t'(VLMAX) : req.wdata;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mtvec_q    <= RESET_VECTOR;
            vl_q       <= '0;
            vtype_q    <= '0;
            fflags_q   <= '0;
            vxsat_q    <= 1'b0;
            minstret_q <= '0;
            fs_dirty_o <= 1'b0;
        end else begin
            mscratch_q <= mscratch_d;
            mepc_q     <= mepc_d;
            mcause_q   <= mcause_d;
            mtval_q    <= mtval_d;
            mtvec_q    <= mtvec_d;
            vl_q       <= vl_d;
            vtype_q    <= vtype_d;
            fflags_q   <= fflags_d;
            vxsat_q    <= vxsat_d;
            minstret_q <= minstret_d;
            if (req.freg_modified) begin
                fs_dirty_o <= 1'b1;       // Cleared only by reset
            end
        end
    end

    // Traps go to mtvec and every other system op to mepc
    assign redirect_valid_o = req.exception || (req.ena && (req.cmd == CSR_CMD_SYS));
    assign redirect_pc_o    = req.exception ? mtvec_q : mepc_q;

endmodule

// ==== logic/commit_csr_top.sv ====
`timescale 1ns/1ps

module commit_csr_top (
    input  logic                                  clk_i,
    input  logic                                  arst_n_i,
    input  logic                                  commit_xcpt_i,
    input  commit_csr_pkg::bus64_t                result_gl_i,
    input  commit_csr_pkg::csr_addr_t             csr_addr_gl_i,
    input  commit_csr_pkg::csr_addr_t             vsetvl_vtype_i,
    input  commit_csr_pkg::gl_instruction_t [1:0] instruction_to_commit_i,
    input  logic                                  commit_store_or_amo_i,
    input  logic                                  mem_commit_stall_i,
    input  commit_csr_pkg::exception_t            exception_mem_commit_i,
    input  commit_csr_pkg::exception_t            exception_gl_i,
    output logic [1:0]                            retire_inst_o,
    output logic                                  csr_ena_int_o,
    output commit_csr_pkg::bus64_t                csr_rdata_o,
    output logic                                  csr_illegal_o,
    output logic                                  fs_dirty_o,
    output logic                                  redirect_valid_o,
    output commit_csr_pkg::bus64_t                redirect_pc_o
);

    csr_req_if csr_req ();

    // Commit stage decoder
    csr_interface i_csr_interface (
        .commit_xcpt_i          (commit_xcpt_i),
        .result_gl_i            (result_gl_i),
        .csr_addr_gl_i          (csr_addr_gl_i),
        .vsetvl_vtype_i         (vsetvl_vtype_i),
        .instruction_to_commit_i(instruction_to_commit_i),
        .commit_store_or_amo_i  (commit_store_or_amo_i),
        .mem_commit_stall_i     (mem_commit_stall_i),
        .exception_mem_commit_i (exception_mem_commit_i),
        .exception_gl_i         (exception_gl_i),
        .csr_ena_int_o          (csr_ena_int_o),
        .retire_inst_o          (retire_inst_o),
        .req                    (csr_req.requester)
    );

    // Machine-mode CSRs
    csr_file i_csr_file (
        .clk_i           (clk_i),
        .arst_n_i        (arst_n_i),
        .req             (csr_req.responder),
        .fs_dirty_o      (fs_dirty_o),
        .redirect_valid_o(redirect_valid_o),
        .redirect_pc_o   (redirect_pc_o)
    );

    // Same-cycle response back to the core
    assign csr_rdata_o   = csr_req.rdata;
    assign csr_illegal_o = csr_req.illegal;

endmodule

// ==== test/tb_commit_csr_model.svh ====
`ifndef TB_COMMIT_CSR_MODEL_SVH
`define TB_COMMIT_CSR_MODEL_SVH

// Predicted CSR state between edges
bus64_t     m_mscratch, m_mepc, m_mcause, m_mtval, m_mtvec;
bus64_t     m_vl, m_vtype, m_minstret;
logic [4:0] m_fflags;
logic       m_vxsat;
logic       m_fs_dirty;

// Expected same-cycle outputs
logic [1:0] exp_retire;
logic       exp_ena, exp_illegal, exp_fs_dirty, exp_rvalid;
bus64_t     exp_rdata, exp_rpc;

task automatic reset_model();
    m_mscratch = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_mtvec    = RESET_VECTOR;    // Only CSR with a nonzero reset value
    m_vl       = '0;
    m_vtype    = '0;
    m_minstret = '0;
    m_fflags   = '0;
    m_vxsat    = 1'b0;
    m_fs_dirty = 1'b0;
endtask

function automatic logic csr_known(input csr_addr_t a);
    return a inside {ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MTVEC,
                     ADDR_FFLAGS, ADDR_VXSAT, ADDR_VL, ADDR_VTYPE, ADDR_MINSTRET};
endfunction

function automatic bus64_t read_csr(input csr_addr_t a);
    case (a)
        ADDR_MSCRATCH: return m_mscratch;
        ADDR_MEPC:     return m_mepc;
        ADDR_MCAUSE:   return m_mcause;
        ADDR_MTVAL:    return m_mtval;
        ADDR_MTVEC:    return m_mtvec;
        ADDR_FFLAGS:   return {59'd0, m_fflags};
        ADDR_VXSAT:    return {63'd0, m_vxsat};
        ADDR_VL:       return m_vl;
        ADDR_VTYPE:    return m_vtype;
        ADDR_MINSTRET: return m_minstret;
        default:       return '0;     // Unknown address reads as zero
    endcase
endfunction

task automatic write_csr(input csr_addr_t a, input bus64_t v);
    case (a)
        ADDR_MSCRATCH: m_mscratch = v;
        ADDR_MEPC:     m_mepc = v;
        ADDR_MCAUSE:   m_mcause = v;
        ADDR_MTVAL:    m_mtval = v;
        ADDR_MTVEC:    m_mtvec = v;
        ADDR_FFLAGS:   m_fflags = v[4:0];
        ADDR_VXSAT:    m_vxsat = v[0];
        ADDR_VL:       m_vl = v;
        ADDR_VTYPE:    m_vtype = v;
        ADDR_MINSTRET: m_minstret = v;
        default:       ;
    endcase
endtask

// Expected outputs for the driven inputs and the state after the next edge
task automatic predict_cycle();
    gl_instruction_t s0;
    gl_instruction_t s1;
    csr_cmd_t        cmd;
    csr_addr_t       addr;
    bus64_t          data;
    bus64_t          cur;
    logic            known;
    logic            blocked;
    logic [1:0]      csr_ret;
    logic [4:0]      fp;
    s0   = slots[0];
    s1   = slots[1];
    cmd  = CSR_CMD_NOPE;
    addr = csr_addr;
    data = result;
    if (s0.valid && !s0.ex_valid) begin
        case (s0.instr_type)
            CSRRW, CSRRWI: cmd = (s0.rd == 5'd0) ? CSR_CMD_WRITE : CSR_CMD_RW;
            CSRRS, CSRRSI: cmd = (s0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_SET;
            CSRRC, CSRRCI: cmd = (s0.rs1 == 5'd0) ? CSR_CMD_READ : CSR_CMD_CLEAR;
            ECALL, EBREAK, MRET, WFI, SFENCE_VMA: cmd = CSR_CMD_SYS;
            VSETVL, VSETVLI: cmd = (s0.rs1 == 5'd0) ? CSR_CMD_VSETVLMAX : CSR_CMD_VSETVL;
            VSETIVLI: cmd = CSR_CMD_VSETVL;     // Immediate AVL never asks for the maximum
            default: cmd = CSR_CMD_NOPE;
        endcase
    end
    if (s0.instr_type inside {CSRRWI, CSRRSI, CSRRCI}) data = {59'd0, s0.rs1};
    if (s0.instr_type inside {VSETVL, VSETVLI, VSETIVLI}) addr = vtype_addr;
    exp_ena     = (cmd != CSR_CMD_NOPE);
    known       = csr_known(addr);
    cur         = read_csr(addr);
    exp_rdata   = cur;
    exp_illegal = exp_ena && (cmd != CSR_CMD_SYS) && !known;

    // Slot 1 retires alongside slot 0 only if nothing serializes it
    blocked = exp_ena || !s1.valid || s1.ex_valid || s1.stall_csr_fence
           || (s1.mem_type inside {STORE, AMO})
           || (s1.instr_type inside {CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
                                     ECALL, EBREAK, MRET, WFI, FENCE, FENCE_I,
                                     SFENCE_VMA, VSETVL, VSETVLI, VSETIVLI});
    exp_retire = 2'b00;
    csr_ret    = 2'b00;
    if (s0.valid && xcpt) begin
        exp_retire = 2'b01;           // Leaves the pipe without counting
    end else if (s0.valid && !stall) begin
        exp_retire = blocked ? 2'b01 : 2'b11;
        csr_ret    = exp_retire;
    end
    exp_rvalid   = xcpt || (cmd == CSR_CMD_SYS);
    exp_rpc      = xcpt ? m_mtvec : m_mepc;
    exp_fs_dirty = m_fs_dirty;

    fp = (exp_retire[0] ? s0.fp_status : 5'd0) | (exp_retire[1] ? s1.fp_status : 5'd0);
    m_fflags   = m_fflags | fp;
    m_vxsat    = m_vxsat | (exp_retire[0] & s0.vs_ovf) | (exp_retire[1] & s1.vs_ovf);
    m_fs_dirty = m_fs_dirty | (exp_retire[0] & s0.fregfile_we)
                            | (exp_retire[1] & s1.fregfile_we);
    m_minstret = m_minstret + 64'(csr_ret[0]) + 64'(csr_ret[1]);
    if (xcpt) begin
        m_mcause = store_amo ? exc_mem.cause : exc_gl.cause;
        m_mepc   = s0.pc;
        m_mtval  = store_amo ? exc_mem.origin : exc_gl.origin;
    end else if (known && (cmd inside {CSR_CMD_WRITE, CSR_CMD_RW})) begin
        write_csr(addr, data);
    end else if (known && (cmd == CSR_CMD_SET)) begin
        write_csr(addr, cur | data);
    end else if (known && (cmd == CSR_CMD_CLEAR)) begin
        write_csr(addr, cur & ~data);
    end else if (known && (cmd == CSR_CMD_VSETVLMAX)) begin
        m_vl = bus64_t'(VLMAX);
    end else if (known && (cmd == CSR_CMD_VSETVL)) begin
        m_vl = data;
    end
endtask

`endif

// ==== test/tb_commit_csr.sv ====
`timescale 1ns/1ps

module tb_commit_csr;
    import commit_csr_pkg::*;

    logic                  clk;
    logic                  arst_n;
    logic                  xcpt;
    bus64_t                result;
    csr_addr_t             csr_addr;
    csr_addr_t             vtype_addr;
    gl_instruction_t [1:0] slots;
    logic                  store_amo;
    logic                  stall;
    exception_t            exc_mem;
    exception_t            exc_gl;
    logic [1:0]            retire;
    logic                  ena;
    bus64_t                rdata;
    logic                  illegal;
    logic                  fs_dirty;
    logic                  rvalid;
    bus64_t                rpc;

    bus64_t    rng_state;
    string     test_name;
    csr_addr_t legal_addrs [10];

    `include "tb_commit_csr_model.svh"

    commit_csr_top i_dut (
        .clk_i                  (clk),
        .arst_n_i               (arst_n),
        .commit_xcpt_i          (xcpt),
        .result_gl_i            (result),
        .csr_addr_gl_i          (csr_addr),
        .vsetvl_vtype_i         (vtype_addr),
        .instruction_to_commit_i(slots),
        .commit_store_or_amo_i  (store_amo),
        .mem_commit_stall_i     (stall),
        .exception_mem_commit_i (exc_mem),
        .exception_gl_i         (exc_gl),
        .retire_inst_o          (retire),
        .csr_ena_int_o          (ena),
        .csr_rdata_o            (rdata),
        .csr_illegal_o          (illegal),
        .fs_dirty_o             (fs_dirty),
        .redirect_valid_o       (rvalid),
        .redirect_pc_o          (rpc)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic bus64_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_word(input string what, input bus64_t exp, input bus64_t act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_retire(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        if (exp !== act) begin
            $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_idle();
        slots      = '0;
        xcpt       = 1'b0;
        stall      = 1'b0;
        store_amo  = 1'b0;
        result     = '0;
        csr_addr   = '0;
        vtype_addr = ADDR_VTYPE;
        exc_mem    = '0;
        exc_gl     = '0;
    endtask

    task automatic randomize_slot(input int idx);
        gl_instruction_t s;
        bus64_t          r;
        r = next_rand();
        s = '0;
        s.valid = (r[2:0] != 3'd0);
        if (r[3]) begin
            s.instr_type = instr_type_t'(r[8:4] % 5'd6 + 5'd1);    // CSR forms only
        end else begin
            s.instr_type = instr_type_t'(r[8:4] % 5'd17);
        end
        s.mem_type        = mem_type_t'(r[12:11]);
        s.rd              = (r[14:13] == 2'd0) ? 5'd0 : r[19:15];
        s.rs1             = (r[21:20] == 2'd0) ? 5'd0 : r[26:22];
        s.fp_status       = (r[29:27] == 3'd0) ? r[34:30] : 5'd0;
        s.vs_ovf          = (r[38:35] == 4'd0);
        s.fregfile_we     = (r[42:39] == 4'd0);
        s.stall_csr_fence = (r[46:43] == 4'd0);
        r    = next_rand();
        s.pc = {r[63:2], 2'b00};
        slots[idx] = s;
    endtask

    task automatic drive_random();
        bus64_t r;
        randomize_slot(0);
        randomize_slot(1);
        r = next_rand();
        stall            = (r[2:0] == 3'd0);
        xcpt             = slots[0].valid && (r[6:3] == 4'd0);
        slots[0].ex_valid = xcpt;                 // Exception belongs to slot 0
        slots[1].ex_valid = (r[9:7] == 3'd0);
        store_amo        = r[10];
        result           = r[11] ? next_rand() : {58'd0, r[17:12]};
        // Mostly legal addresses with a random one now and then
        csr_addr   = (r[21:18] == 4'd0) ? r[33:22] : legal_addrs[r[37:34] % 4'd10];
        vtype_addr = (r[41:38] == 4'd0) ? r[53:42] : ADDR_VTYPE;
        exc_mem    = {next_rand(), next_rand()};
        exc_gl     = {next_rand(), next_rand()};
    endtask

    task automatic predict_and_check();
        predict_cycle();
        check_retire("retire_inst", exp_retire, retire);
        check_flag("csr_ena", exp_ena, ena);
        if (exp_ena) check_word("csr_rdata", exp_rdata, rdata);
        check_flag("csr_illegal", exp_illegal, illegal);
        check_flag("fs_dirty", exp_fs_dirty, fs_dirty);
        check_flag("redirect_valid", exp_rvalid, rvalid);
        if (exp_rvalid) check_word("redirect_pc", exp_rpc, rpc);
    endtask

    task automatic step_random();
        @(posedge clk);
        #1;
        drive_random();
        #2.5;                         // Sample just before the next edge
        predict_and_check();
    endtask

    // CSRRS with rs1 zero on every implemented CSR
    task automatic read_back_all(input string name);
        gl_instruction_t rd_instr;
        test_name           = name;
        rd_instr            = '0;
        rd_instr.valid      = 1'b1;
        rd_instr.instr_type = CSRRS;
        rd_instr.rd         = 5'd1;
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1;
            drive_idle();
            slots[0] = rd_instr;
            csr_addr = legal_addrs[i];
            #2.5;
            predict_and_check();
        end
    endtask

    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (fs_dirty !== 1'b0 || ena !== 1'b0 || retire !== 2'b00) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: DUT outputs did not settle after reset release");
                abort_run();
            end
        end
    endtask

    task automatic drain_commit();
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        drive_idle();
        while (ena !== 1'b0 || rvalid !== 1'b0 || retire !== 2'b00) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) begin
                $display("Timeout: commit path stayed busy with idle inputs");
                abort_run();
            end
        end
    endtask

    initial begin
        legal_addrs = '{ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MTVEC,
                        ADDR_FFLAGS, ADDR_VXSAT, ADDR_VL, ADDR_VTYPE, ADDR_MINSTRET};
        rng_state = 64'd15240;
        test_name = "reset";
        arst_n    = 1'b0;
        drive_idle();
        reset_model();
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        wait_reset_release();
        read_back_all("reset_values");
        test_name = "random_commit";
        repeat (3000) step_random();
        read_back_all("final_state");
        drain_commit();
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+test
logic/commit_csr_pkg.sv
logic/csr_req_if.sv
logic/csr_interface.sv
logic/csr_file.sv
logic/commit_csr_top.sv
test/tb_commit_csr.sv

// ==== Makefile ====
# Verilator build and run of the commit-to-CSR testbench

sim:
	verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
		--top-module tb_commit_csr -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
